/* design/cpu_pkg.sv */
package cpu_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_LUI = 4'd8
    } alu_op_t;

    // major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // funct codes under OP_RTYPE
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, seen through either format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    typedef struct packed {
        alu_op_t    op;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        word_t      imm;
        logic       use_imm;
        logic       wen;
    } uop_t;

    typedef struct packed {
        alu_op_t    op;
        word_t      operand_a;
        word_t      operand_b;
        logic [4:0] shamt;
        reg_idx_t   rd;
    } exec_req_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
    } result_t;

    typedef struct packed {
        logic    en;
        result_t res;
    } retire_t;

endpackage

/* design/uop_decoder.sv */
`timescale 1ns/10ps

module uop_decoder (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  cpu_pkg::instr_u inst,
    output logic            uop_valid,
    input  logic            uop_ready,
    output cpu_pkg::uop_t   uop
);

    cpu_pkg::uop_t dec;
    logic          accept;

    // new word allowed when the held uop leaves this cycle
    assign in_ready = !uop_valid || uop_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        dec       = '0;
        dec.op    = cpu_pkg::ALU_ADD;
        dec.rs    = inst.r.rs;
        dec.shamt = inst.r.shamt;
        if (inst.r.opcode == cpu_pkg::OP_RTYPE) begin
            dec.rt  = inst.r.rt;
            dec.rd  = inst.r.rd;
            dec.wen = 1'b1;
            case (inst.r.funct)
                cpu_pkg::FN_ADD: dec.op = cpu_pkg::ALU_ADD;
                cpu_pkg::FN_SUB: dec.op = cpu_pkg::ALU_SUB;
                cpu_pkg::FN_AND: dec.op = cpu_pkg::ALU_AND;
                cpu_pkg::FN_OR:  dec.op = cpu_pkg::ALU_OR;
                cpu_pkg::FN_XOR: dec.op = cpu_pkg::ALU_XOR;
                cpu_pkg::FN_SLT: dec.op = cpu_pkg::ALU_SLT;
                // shifts only read rt
                cpu_pkg::FN_SLL: begin
                    dec.op = cpu_pkg::ALU_SLL;
                    dec.rs = '0;
                end
                cpu_pkg::FN_SRL: begin
                    dec.op = cpu_pkg::ALU_SRL;
                    dec.rs = '0;
                end
                default: dec.wen = 1'b0;
            endcase
        end else begin
            // i-type writes rt, no second source
            dec.rd      = inst.i.rt;
            dec.use_imm = 1'b1;
            dec.wen     = 1'b1;
            dec.imm     = {{16{inst.i.imm[15]}}, inst.i.imm};
            case (inst.i.opcode)
                cpu_pkg::OP_ADDI: dec.op = cpu_pkg::ALU_ADD;
                cpu_pkg::OP_SLTI: dec.op = cpu_pkg::ALU_SLT;
                cpu_pkg::OP_ANDI: begin
                    dec.op  = cpu_pkg::ALU_AND;
                    dec.imm = {16'h0, inst.i.imm};
                end
                cpu_pkg::OP_ORI: begin
                    dec.op  = cpu_pkg::ALU_OR;
                    dec.imm = {16'h0, inst.i.imm};
                end
                cpu_pkg::OP_XORI: begin
                    dec.op  = cpu_pkg::ALU_XOR;
                    dec.imm = {16'h0, inst.i.imm};
                end
                cpu_pkg::OP_LUI: begin
                    dec.op  = cpu_pkg::ALU_LUI;
                    dec.rs  = '0;
                    dec.imm = {16'h0, inst.i.imm};
                end
                default: dec.wen = 1'b0;
            endcase
        end
        // r0 is hardwired
        if (dec.rd == '0) begin
            dec.wen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else if (accept) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop <= dec;
        end
    end

    a_uop_hold: assert property (@(posedge clk) disable iff (!rst_n)
        uop_valid && !uop_ready |=> uop_valid && $stable(uop))
        else $error("uop changed while stalled");

endmodule

/* design/operand_issue.sv */
`timescale 1ns/10ps

module operand_issue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               uop_valid,
    output logic               uop_ready,
    input  cpu_pkg::uop_t      uop,
    output logic               exec_valid,
    input  logic               exec_ready,
    output cpu_pkg::exec_req_t exec,
    input  cpu_pkg::retire_t   retire
);

    cpu_pkg::word_t               regs [cpu_pkg::NUM_REGS];
    logic [cpu_pkg::NUM_REGS-1:0] busy;
    cpu_pkg::word_t               rs_val;
    cpu_pkg::word_t               rt_val;
    cpu_pkg::exec_req_t           next_req;
    logic                         hazard;
    logic                         slot_free;
    logic                         issue_fire;

    assign rs_val = (uop.rs == '0) ? '0 : regs[uop.rs];
    assign rt_val = (uop.rt == '0) ? '0 : regs[uop.rt];

    // no bypass, so wait for both sources and the old rd write
    assign hazard    = busy[uop.rs] || busy[uop.rt] || busy[uop.rd];
    assign slot_free = !exec_valid || exec_ready;

    // a uop that writes nothing is simply consumed here
    assign uop_ready  = !uop.wen || (!hazard && slot_free);
    assign issue_fire = uop_valid && uop.wen && !hazard && slot_free;

    always_comb begin
        next_req.op        = uop.op;
        next_req.operand_a = rs_val;
        next_req.operand_b = uop.use_imm ? uop.imm : rt_val;
        next_req.shamt     = uop.shamt;
        next_req.rd        = uop.rd;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.en) begin
            regs[retire.res.rd] <= retire.res.value;
        end
    end

    // scoreboard, set on issue and cleared on queue push
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (retire.en) begin
                busy[retire.res.rd] <= 1'b0;
            end
            if (issue_fire) begin
                busy[uop.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_valid <= 1'b0;
        end else if (issue_fire) begin
            exec_valid <= 1'b1;
        end else if (exec_ready) begin
            exec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            exec <= next_req;
        end
    end

    // the rd still held in the issue register has its bit set
    a_set_clear_bit: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire && exec_valid |-> exec.rd != uop.rd)
        else $error("issue set a busy bit that was already set");

    a_clear_set_bit: assert property (@(posedge clk) disable iff (!rst_n)
        retire.en |-> busy[retire.res.rd])
        else $error("retire cleared a busy bit that was already clear");

endmodule

/* design/alu_execute.sv */
`timescale 1ns/10ps

module alu_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               exec_valid,
    output logic               exec_ready,
    input  cpu_pkg::exec_req_t exec,
    output logic               res_valid,
    input  logic               res_ready,
    output cpu_pkg::result_t   res
);

    cpu_pkg::word_t value;
    logic           accept;

    assign exec_ready = !res_valid || res_ready;
    assign accept     = exec_valid && exec_ready;

    always_comb begin
        case (exec.op)
            cpu_pkg::ALU_ADD: value = exec.operand_a + exec.operand_b;
            cpu_pkg::ALU_SUB: value = exec.operand_a - exec.operand_b;
            cpu_pkg::ALU_AND: value = exec.operand_a & exec.operand_b;
            cpu_pkg::ALU_OR:  value = exec.operand_a | exec.operand_b;
            cpu_pkg::ALU_XOR: value = exec.operand_a ^ exec.operand_b;
            // signed compare
            cpu_pkg::ALU_SLT: begin
                value = {31'h0, $signed(exec.operand_a) < $signed(exec.operand_b)};
            end
            cpu_pkg::ALU_SLL: value = exec.operand_b << exec.shamt;
            cpu_pkg::ALU_SRL: value = exec.operand_b >> exec.shamt;
            // imm arrives zero-extended
            cpu_pkg::ALU_LUI: value = {exec.operand_b[15:0], 16'h0};
            default:          value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (accept) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res.rd    <= exec.rd;
            res.value <= value;
        end
    end

endmodule

/* design/result_queue.sv */
`timescale 1ns/10ps

module result_queue #(
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             res_valid,
    output logic             res_ready,
    input  cpu_pkg::result_t res,
    output cpu_pkg::retire_t retire,
    output logic             result_valid,
    input  logic             result_ready,
    output cpu_pkg::result_t result
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cpu_pkg::result_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign res_ready    = (count != CNT_W'(DEPTH));
    assign result_valid = (count != '0);
    assign result       = mem[rd_ptr];
    assign push         = res_valid && res_ready;
    assign pop          = result_valid && result_ready;

    // the write-back port, same cycle as the push
    assign retire.en  = push;
    assign retire.res = res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= res;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count < CNT_W'(DEPTH) ##1 count <= CNT_W'(DEPTH))
        else $error("push into a full result queue");

endmodule

/* design/backend_core.sv */
`timescale 1ns/10ps

module backend_core #(
    parameter int RESULT_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    output logic             inst_ready,
    input  cpu_pkg::instr_u  inst,
    output logic             result_valid,
    input  logic             result_ready,
    output cpu_pkg::result_t result
);

    logic               uop_valid;
    logic               uop_ready;
    cpu_pkg::uop_t      uop;
    logic               exec_valid;
    logic               exec_ready;
    cpu_pkg::exec_req_t exec;
    logic               res_valid;
    logic               res_ready;
    cpu_pkg::result_t   res;
    cpu_pkg::retire_t   retire;

    uop_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (inst_valid),
        .in_ready  (inst_ready),
        .inst      (inst),
        .uop_valid (uop_valid),
        .uop_ready (uop_ready),
        .uop       (uop)
    );

    operand_issue u_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .uop_valid  (uop_valid),
        .uop_ready  (uop_ready),
        .uop        (uop),
        .exec_valid (exec_valid),
        .exec_ready (exec_ready),
        .exec       (exec),
        .retire     (retire)
    );

    alu_execute u_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_valid (exec_valid),
        .exec_ready (exec_ready),
        .exec       (exec),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res        (res)
    );

    result_queue #(
        .DEPTH (RESULT_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .res          (res),
        .retire       (retire),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

endmodule

/* bench/backend_ref.svh */
`ifndef BACKEND_REF_SVH
`define BACKEND_REF_SVH

localparam logic [31:0] LCG_SEED = 32'd16;

// architectural state of the model, r0 is never written
cpu_pkg::word_t model_regs [cpu_pkg::NUM_REGS] = '{default: '0};

function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic cpu_pkg::instr_u encode_rtype(input logic [5:0] funct,
        input cpu_pkg::reg_idx_t rd, input cpu_pkg::reg_idx_t rs,
        input cpu_pkg::reg_idx_t rt, input logic [4:0] shamt);
    cpu_pkg::instr_u w;
    w.r.opcode = cpu_pkg::OP_RTYPE;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = shamt;
    w.r.funct  = funct;
    return w;
endfunction

function automatic cpu_pkg::instr_u encode_itype(input logic [5:0] opcode,
        input cpu_pkg::reg_idx_t rt, input cpu_pkg::reg_idx_t rs, input logic [15:0] imm);
    cpu_pkg::instr_u w;
    w.i.opcode = opcode;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
endfunction

// executes one word on the model, en tells whether a result is due
function automatic cpu_pkg::retire_t ref_exec(input logic [31:0] word);
    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [4:0]        shamt;
    logic [15:0]       imm;
    cpu_pkg::reg_idx_t dest;
    cpu_pkg::word_t    a;
    cpu_pkg::word_t    b;
    cpu_pkg::word_t    sx;
    cpu_pkg::word_t    zx;
    cpu_pkg::word_t    value;
    cpu_pkg::retire_t  ret;
    logic              due;
    opcode = word[31:26];
    a      = model_regs[word[25:21]];
    b      = model_regs[word[20:16]];
    shamt  = word[10:6];
    funct  = word[5:0];
    imm    = word[15:0];
    sx     = {{16{imm[15]}}, imm};
    zx     = {16'h0, imm};
    due    = 1'b1;
    value  = '0;
    if (opcode == cpu_pkg::OP_RTYPE) begin
        dest = word[15:11];
        case (funct)
            cpu_pkg::FN_ADD: value = a + b;
            cpu_pkg::FN_SUB: value = a - b;
            cpu_pkg::FN_AND: value = a & b;
            cpu_pkg::FN_OR:  value = a | b;
            cpu_pkg::FN_XOR: value = a ^ b;
            cpu_pkg::FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::FN_SLL: value = b << shamt;
            cpu_pkg::FN_SRL: value = b >> shamt;
            default:         due = 1'b0;
        endcase
    end else begin
        dest = word[20:16];
        case (opcode)
            cpu_pkg::OP_ADDI: value = a + sx;
            cpu_pkg::OP_SLTI: value = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            cpu_pkg::OP_ANDI: value = a & zx;
            cpu_pkg::OP_ORI:  value = a | zx;
            cpu_pkg::OP_XORI: value = a ^ zx;
            cpu_pkg::OP_LUI:  value = {imm, 16'h0};
            default:          due = 1'b0;
        endcase
    end
    if (dest == '0) begin
        due = 1'b0;
    end
    if (due) begin
        model_regs[dest] = value;
    end
    ret.en        = due;
    ret.res.rd    = dest;
    ret.res.value = value;
    return ret;
endfunction

`endif

/* bench/backend_tb.sv */
`timescale 1ns/10ps

module backend_tb;

    localparam int N_DIRECTED      = 120;
    localparam int N_RANDOM        = 300;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 500;

    logic             clk = 1'b0;
    logic             rst_n = 1'b0;
    logic             inst_valid = 1'b0;
    cpu_pkg::instr_u  inst = '0;
    logic             inst_ready;
    logic             result_valid;
    logic             result_ready = 1'b0;
    cpu_pkg::result_t result;

    `include "backend_ref.svh"

    logic             bp_enable = 1'b0;
    logic [31:0]      stim_state = LCG_SEED;
    logic [31:0]      ready_state = LCG_SEED;
    cpu_pkg::result_t exp_q [$];
    int               result_mismatches = 0;
    int               flag_mismatches = 0;
    int               stray_results = 0;
    int               leftover = 0;
    int               results_checked = 0;

    logic [5:0] r_functs [8] = '{cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND,
        cpu_pkg::FN_OR, cpu_pkg::FN_XOR, cpu_pkg::FN_SLT, cpu_pkg::FN_SLL, cpu_pkg::FN_SRL};
    logic [5:0] i_opcodes [6] = '{cpu_pkg::OP_ADDI, cpu_pkg::OP_SLTI, cpu_pkg::OP_ANDI,
        cpu_pkg::OP_ORI, cpu_pkg::OP_XORI, cpu_pkg::OP_LUI};

    backend_core #(
        .RESULT_DEPTH (4)
    ) backend_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    always #50 clk = ~clk;

    task automatic check_result(input cpu_pkg::result_t got, input cpu_pkg::result_t want);
        if (got !== want) begin
            result_mismatches++;
            $display("mismatch at %0t: result rd %0d value %h, expected rd %0d value %h",
                $time, got.rd, got.value, want.rd, want.value);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            flag_mismatches++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d result mismatches, %0d flag mismatches, %0d unexpected, %0d missing",
            result_mismatches, flag_mismatches, stray_results, leftover);
    endtask

    function automatic logic [31:0] next_rand(input logic [31:0] range);
        stim_state = lcg_step(stim_state);
        return {16'h0, stim_state[31:16]} % range;
    endfunction

    // mostly known ops on r0..r7, so hazards are frequent
    function automatic cpu_pkg::instr_u random_inst();
        logic [31:0]       sel;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::reg_idx_t rs;
        cpu_pkg::reg_idx_t rt;
        logic [4:0]        shamt;
        logic [15:0]       imm;
        sel   = next_rand(16);
        rd    = cpu_pkg::reg_idx_t'(next_rand(8));
        rs    = cpu_pkg::reg_idx_t'(next_rand(8));
        rt    = cpu_pkg::reg_idx_t'(next_rand(8));
        shamt = 5'(next_rand(32));
        imm   = 16'(next_rand(65536));
        if (sel < 8) begin
            return encode_rtype(r_functs[sel[2:0]], rd, rs, rt, shamt);
        end else if (sel < 14) begin
            return encode_itype(i_opcodes[3'(sel - 8)], rd, rs, imm);
        end else if (sel == 14) begin
            return encode_itype(6'h3b, rd, rs, imm);
        end
        return encode_rtype(6'h3f, rd, rs, rt, shamt);
    endfunction

    // returns at the negedge before the handshake edge
    task automatic send_inst(input cpu_pkg::instr_u w, input bit gaps);
        if (gaps) begin
            while (next_rand(4) == 0) begin
                @(posedge clk);
                inst_valid <= 1'b0;
            end
        end
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        @(negedge clk);
        while (!inst_ready) begin
            @(negedge clk);
        end
    endtask

    // destination first, as in assembly
    task automatic send_r(input logic [5:0] funct, input int rd, input int rs, input int rt,
            input int shamt);
        send_inst(encode_rtype(funct, cpu_pkg::reg_idx_t'(rd), cpu_pkg::reg_idx_t'(rs),
            cpu_pkg::reg_idx_t'(rt), 5'(shamt)), 1'b0);
    endtask

    task automatic send_i(input logic [5:0] opcode, input int rt, input int rs, input int imm);
        send_inst(encode_itype(opcode, cpu_pkg::reg_idx_t'(rt), cpu_pkg::reg_idx_t'(rs),
            16'(imm)), 1'b0);
    endtask

    // inputs change on posedge, so both handshakes are settled here
    always @(negedge clk) begin : monitor
        cpu_pkg::retire_t due;
        cpu_pkg::result_t want;
        if (rst_n && result_valid && result_ready) begin
            if (exp_q.size() == 0) begin
                stray_results++;
                $display("unexpected result at %0t: rd %0d value %h arrived with none expected",
                    $time, result.rd, result.value);
            end else begin
                want = exp_q.pop_front();
                check_result(result, want);
                results_checked++;
            end
        end
        if (rst_n && inst_valid && inst_ready) begin
            due = ref_exec(inst);
            if (due.en) begin
                exp_q.push_back(due.res);
            end
        end
    end

    always @(posedge clk) begin : ready_drive
        if (bp_enable) begin
            ready_state = lcg_step(ready_state);
            result_ready <= ready_state[29];
        end else begin
            result_ready <= 1'b1;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        report_counts();
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(result_valid, 1'b0, "result_valid after reset");
        check_flag(inst_ready, 1'b1, "inst_ready after reset");

        // reset values first, then each register gets its own index
        for (int k = 1; k < cpu_pkg::NUM_REGS; k++) begin
            send_i(cpu_pkg::OP_ORI, k, k, 0);
        end
        for (int k = 1; k < cpu_pkg::NUM_REGS; k++) begin
            send_i(cpu_pkg::OP_ORI, k, 0, k);
        end

        // operands: r1 negative, r2 small positive, r3 = -3, r4 a mask
        send_i(cpu_pkg::OP_LUI, 1, 0, 'h8000);
        send_i(cpu_pkg::OP_ORI, 1, 1, 'h0005);
        send_i(cpu_pkg::OP_ADDI, 2, 0, 7);
        send_i(cpu_pkg::OP_ADDI, 3, 0, -3);
        send_i(cpu_pkg::OP_ORI, 4, 0, 'hf0f0);
        send_r(cpu_pkg::FN_ADD, 5, 1, 2, 0);
        send_r(cpu_pkg::FN_ADD, 6, 1, 1, 0);
        send_r(cpu_pkg::FN_SUB, 7, 2, 3, 0);
        send_r(cpu_pkg::FN_SUB, 8, 0, 2, 0);
        send_r(cpu_pkg::FN_AND, 9, 1, 4, 0);
        send_r(cpu_pkg::FN_OR, 10, 3, 4, 0);
        send_r(cpu_pkg::FN_XOR, 11, 3, 4, 0);
        send_r(cpu_pkg::FN_SLT, 12, 1, 2, 0);
        send_r(cpu_pkg::FN_SLT, 13, 2, 1, 0);
        send_r(cpu_pkg::FN_SLT, 14, 3, 2, 0);
        send_r(cpu_pkg::FN_SLL, 15, 0, 4, 4);
        send_r(cpu_pkg::FN_SLL, 16, 0, 1, 31);
        send_r(cpu_pkg::FN_SRL, 17, 0, 1, 3);
        send_r(cpu_pkg::FN_SRL, 18, 0, 3, 0);
        send_i(cpu_pkg::OP_ADDI, 19, 2, -1);
        send_i(cpu_pkg::OP_SLTI, 20, 3, -2);
        send_i(cpu_pkg::OP_SLTI, 21, 2, 'h8000);
        send_i(cpu_pkg::OP_ANDI, 22, 1, 'hffff);
        send_i(cpu_pkg::OP_ORI, 23, 0, 'h8000);
        send_i(cpu_pkg::OP_XORI, 24, 3, 'hffff);
        send_i(cpu_pkg::OP_LUI, 25, 0, 'habcd);
        send_i(cpu_pkg::OP_ADDI, 26, 1, 'h8000);

        // raw and waw chains, each one waits on the scoreboard
        for (int k = 0; k < 6; k++) begin
            send_i(cpu_pkg::OP_ADDI, 1, 1, 3);
        end
        send_r(cpu_pkg::FN_ADD, 2, 1, 1, 0);
        send_r(cpu_pkg::FN_SUB, 2, 2, 1, 0);
        send_i(cpu_pkg::OP_ADDI, 3, 0, 5);
        send_i(cpu_pkg::OP_ADDI, 3, 0, 6);
        send_r(cpu_pkg::FN_OR, 4, 3, 2, 0);
        send_r(cpu_pkg::FN_SLL, 4, 0, 4, 2);
        send_r(cpu_pkg::FN_XOR, 5, 4, 1, 0);

        // no-ops, then r0 and r5 read back
        send_i(cpu_pkg::OP_ADDI, 0, 0, 5);
        send_r(cpu_pkg::FN_ADD, 0, 1, 2, 0);
        send_i(6'h3f, 5, 1, 'h1234);
        send_r(6'h3f, 5, 1, 2, 0);
        send_i(cpu_pkg::OP_ORI, 6, 0, 0);
        send_r(cpu_pkg::FN_OR, 7, 0, 0, 0);
        send_i(cpu_pkg::OP_ORI, 8, 5, 0);

        // random stream with stalls on both sides
        bp_enable = 1'b1;
        for (int k = 0; k < N_RANDOM; k++) begin
            send_inst(random_inst(), 1'b1);
        end
        bp_enable = 1'b0;
        @(posedge clk);
        inst_valid <= 1'b0;

        for (int n = 0; n < 200 && exp_q.size() != 0; n++) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            leftover = exp_q.size();
            $display("%0d expected results never came out of the DUT", leftover);
        end

        $display("%0d results checked", results_checked);
        report_counts();
        if (result_mismatches + flag_mismatches + stray_results + leftover == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
design/cpu_pkg.sv
design/uop_decoder.sv
design/operand_issue.sv
design/alu_execute.sv
design/result_queue.sv
design/backend_core.sv
bench/backend_tb.sv
+incdir+bench

/* run.sh */
#!/bin/sh
# Build the backend testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module backend_tb -f sources.f -o backend_sim &&
./obj_dir/backend_sim | tee /dev/stderr | grep -qx "TB PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
